// File: Bender.yml
package:
  name: tcls

sources:
  - include_dirs:
      - common
    files:
      - common/tcls_bus_pkg.sv
      - common/tcls_reg_pkg.sv
      - design/bitwise_tmr_voter.sv
      - design/tcls_request_voter.sv
      - design/tcls_recovery_ctrl.sv
      - design/tcls_manager_regs.sv
      - design/tcls_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tcls_tb.sv

// File: common/tcls_bus_pkg.sv
// Core-side and interconnect-side bundles of the lockstep unit
// The core request order keeps the main voting group above the data group

`default_nettype none

`include "tcls_defines.svh"

package tcls_bus_pkg;

  // One core's outgoing requests, also the voted request to the interconnect
  typedef struct packed {
    logic                         irq_ack;
    logic [4:0]                   irq_ack_id;
    logic                         instr_req;
    logic [`TCLS_ADDR_WIDTH-1:0]  instr_addr;
    logic                         data_req;
    logic [`TCLS_ADDR_WIDTH-1:0]  data_addr;
    logic                         data_we;
    logic [`TCLS_DATA_WIDTH-1:0]  data_wdata;
    logic [`TCLS_BE_WIDTH-1:0]    data_be;
  } core_req_t;

  // Interconnect responses, fanned out unchanged to every core
  typedef struct packed {
    logic                         instr_gnt;
    logic [`TCLS_INSTR_WIDTH-1:0] instr_rdata;
    logic                         instr_rvalid;
    logic                         instr_err;
    logic                         data_gnt;
    logic [`TCLS_DATA_WIDTH-1:0]  data_rdata;
    logic                         data_rvalid;
    logic                         data_err;
  } intc_rsp_t;

  // Static and slow control inputs of a core
  typedef struct packed {
    logic [31:0]                  hart_id;
    logic                         fetch_en;
    logic [`TCLS_ADDR_WIDTH-1:0]  boot_addr;
    logic [31:0]                  irq_x;
    logic                         debug_req;
    // Forwarded only, no counter semantics here
    logic [`TCLS_PERF_WIDTH-1:0]  perf_counters;
  } core_ctrl_t;

endpackage

`default_nettype wire

// File: common/tcls_defines.svh
// Bus widths, counter width and register offsets of the lockstep unit
// Offsets are byte addresses on the 5-bit register bus
// Counter width must not exceed the data width, counters are read as one word

`ifndef TCLS_DEFINES_SVH
`define TCLS_DEFINES_SVH

// Bus widths
`define TCLS_DATA_WIDTH  32
`define TCLS_ADDR_WIDTH  32
`define TCLS_BE_WIDTH    4
`define TCLS_INSTR_WIDTH 32
`define TCLS_PERF_WIDTH  5

// Mismatch counters wrap at this width
`define TCLS_CNT_WIDTH   32

// Register map
`define TCLS_REG_MODE       5'h00
`define TCLS_REG_SP_STORE   5'h04
`define TCLS_REG_MISMATCH_0 5'h08
`define TCLS_REG_MISMATCH_1 5'h0C
`define TCLS_REG_MISMATCH_2 5'h10

`endif

// File: common/tcls_reg_pkg.sv
// Register bus bundles and redundancy state of the lockstep unit
// The bus is a plain strobe bus with a same-cycle response
// State encoding starts at 1, code 0 is never entered

`default_nettype none

`include "tcls_defines.svh"

package tcls_reg_pkg;

  // Single-cycle request strobe
  typedef struct packed {
    logic                        valid;
    logic                        write;
    logic [4:0]                  addr;
    logic [`TCLS_DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`TCLS_DATA_WIDTH-1:0] rdata;
    logic                        error;
  } reg_rsp_t;

  // Redundancy state
  typedef enum logic [1:0] {
    TMR_RUN    = 2'b01,
    TMR_UNLOAD = 2'b10,
    TMR_RELOAD = 2'b11
  } red_mode_e;

  // Field layout of the MODE register
  typedef struct packed {
    logic [`TCLS_DATA_WIDTH-4:0] reserved;
    // Read only, reflects the controller state
    red_mode_e                   state;
    logic                        restore_mode;
  } mode_fields_t;

  // MODE word seen as bus data or as decoded fields
  typedef union packed {
    mode_fields_t                fields;
    logic [`TCLS_DATA_WIDTH-1:0] raw;
  } mode_reg_u;

endpackage

`default_nettype wire

// File: design/bitwise_tmr_voter.sv
// Three-way bitwise majority voter, purely combinational
// error_cba_o bit 0 flags input a, bit 1 input b, bit 2 input c

`timescale 1ns/10ps
`default_nettype none

module bitwise_tmr_voter #(
  parameter int unsigned DataWidth = 32
) (
  input  logic [DataWidth-1:0] a_i,
  input  logic [DataWidth-1:0] b_i,
  input  logic [DataWidth-1:0] c_i,
  output logic [DataWidth-1:0] majority_o,
  output logic                 error_o,
  output logic [2:0]           error_cba_o
);

  logic [DataWidth-1:0] diff_a;
  logic [DataWidth-1:0] diff_b;
  logic [DataWidth-1:0] diff_c;

  // Two out of three per bit
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // Bits where a core disagrees with the vote
  assign diff_a = a_i ^ majority_o;
  assign diff_b = b_i ^ majority_o;
  assign diff_c = c_i ^ majority_o;

  assign error_cba_o[0] = |diff_a;
  assign error_cba_o[1] = |diff_b;
  assign error_cba_o[2] = |diff_c;

  assign error_o = |error_cba_o;

endmodule

`default_nettype wire

// File: design/tcls_manager_regs.sv
// Register block of the lockstep unit on a single-cycle strobe bus
// Response is combinational, writes land at the next clock edge
// Counters are read only and wrap, unmapped offsets answer with error

`timescale 1ns/10ps
`default_nettype none

`include "tcls_defines.svh"

module tcls_manager_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcls_reg_pkg::reg_req_t  reg_req_i,
  input  logic [2:0]              count_inc_i,
  input  tcls_reg_pkg::red_mode_e red_mode_i,
  output tcls_reg_pkg::reg_rsp_t  reg_rsp_o,
  output logic                    restore_mode_o,
  output logic                    sp_store_zero_o
);

  // Only restore_mode is stored, state and reserved bits read back otherwise
  localparam logic [`TCLS_DATA_WIDTH-1:0] ModeWrMask = 'h1;

  tcls_reg_pkg::mode_reg_u               mode_q;
  tcls_reg_pkg::mode_reg_u               mode_rd;
  logic [`TCLS_DATA_WIDTH-1:0]           sp_q;
  logic [2:0][`TCLS_CNT_WIDTH-1:0]       cnt_q;
  logic [`TCLS_DATA_WIDTH-1:0]           rdata;
  logic                                  bad_access;
  logic                                  mode_we;
  logic                                  sp_we;

  // Readback view with the live controller state
  always_comb begin
    mode_rd              = mode_q;
    mode_rd.fields.state = red_mode_i;
  end

  always_comb begin
    rdata      = '0;
    bad_access = 1'b0;
    mode_we    = 1'b0;
    sp_we      = 1'b0;
    case (reg_req_i.addr)
      `TCLS_REG_MODE: begin
        rdata   = mode_rd.raw;
        mode_we = reg_req_i.valid & reg_req_i.write;
      end
      `TCLS_REG_SP_STORE: begin
        rdata = sp_q;
        sp_we = reg_req_i.valid & reg_req_i.write;
      end
      `TCLS_REG_MISMATCH_0: begin
        rdata      = cnt_q[0];
        bad_access = reg_req_i.write;
      end
      `TCLS_REG_MISMATCH_1: begin
        rdata      = cnt_q[1];
        bad_access = reg_req_i.write;
      end
      `TCLS_REG_MISMATCH_2: begin
        rdata      = cnt_q[2];
        bad_access = reg_req_i.write;
      end
      default: bad_access = 1'b1;
    endcase
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = reg_req_i.valid & bad_access;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q.raw <= '0;
      sp_q       <= '0;
    end else begin
      if (mode_we) begin
        mode_q.raw <= reg_req_i.wdata & ModeWrMask;
      end
      if (sp_we) begin
        sp_q <= reg_req_i.wdata;
      end
    end
  end

  // One counter per core, bumped by the controller
  for (genvar i = 0; i < 3; i++) begin : gen_cnt
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (count_inc_i[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign restore_mode_o  = mode_q.fields.restore_mode;
  assign sp_store_zero_o = (sp_q == '0);

endmodule

`default_nettype wire

// File: design/tcls_recovery_ctrl.sv
// Redundancy controller, RUN -> UNLOAD -> RELOAD -> RUN
// Software stores state while in UNLOAD and clears the pointer after reload
// A low fetch_en returns to RUN and suppresses a pending setback

`timescale 1ns/10ps
`default_nettype none

module tcls_recovery_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_en_i,
  input  logic [2:0]              mismatch_core_i,
  input  logic                    restore_mode_i,
  input  logic                    sp_store_zero_i,
  output tcls_reg_pkg::red_mode_e red_mode_o,
  output logic [2:0]              count_inc_o,
  output logic                    setback_o
);

  tcls_reg_pkg::red_mode_e state_d;
  tcls_reg_pkg::red_mode_e state_q;
  logic                    setback_d;
  logic                    setback_q;
  logic                    single_core;

  // Exactly one core out of line, the faulty one is known
  assign single_core = (mismatch_core_i == 3'b001) ||
                       (mismatch_core_i == 3'b010) ||
                       (mismatch_core_i == 3'b100);

  assign count_inc_o = (state_q == tcls_reg_pkg::TMR_RUN && single_core) ?
                       mismatch_core_i : 3'b000;

  always_comb begin
    state_d   = state_q;
    setback_d = 1'b0;
    case (state_q)
      tcls_reg_pkg::TMR_RUN: begin
        // With restore_mode set the mismatch is only counted
        if (mismatch_core_i != 3'b000 && !restore_mode_i) begin
          state_d = tcls_reg_pkg::TMR_UNLOAD;
        end
      end
      tcls_reg_pkg::TMR_UNLOAD: begin
        if (!sp_store_zero_i) begin
          state_d   = tcls_reg_pkg::TMR_RELOAD;
          setback_d = 1'b1;
        end
      end
      tcls_reg_pkg::TMR_RELOAD: begin
        if (sp_store_zero_i) begin
          state_d = tcls_reg_pkg::TMR_RUN;
        end
      end
      default: state_d = tcls_reg_pkg::TMR_RUN;
    endcase

    // Cores held off, nothing to recover
    if (!fetch_en_i) begin
      state_d   = tcls_reg_pkg::TMR_RUN;
      setback_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= tcls_reg_pkg::TMR_RUN;
      setback_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      setback_q <= setback_d;
    end
  end

  assign red_mode_o = state_q;
  assign setback_o  = setback_q;

endmodule

`default_nettype wire

// File: design/tcls_request_voter.sv
// Votes the three core requests into one interconnect request
// Data group disagreement is only reported while the voted data_req is high
// Flags are combinational, they follow the inputs in the same cycle

`timescale 1ns/10ps
`default_nettype none

`include "tcls_defines.svh"

module tcls_request_voter (
  input  tcls_bus_pkg::core_req_t [2:0] core_req_i,
  output tcls_bus_pkg::core_req_t       voted_req_o,
  output logic                          mismatch_o,
  output logic [2:0]                    mismatch_core_o
);

  // irq_ack, irq_ack_id, instr_req, instr_addr, data_req
  localparam int unsigned MainWidth = 1 + 5 + 1 + `TCLS_ADDR_WIDTH + 1;
  // data_addr, data_we, data_wdata, data_be
  localparam int unsigned GrpWidth  = `TCLS_ADDR_WIDTH + 1 + `TCLS_DATA_WIDTH + `TCLS_BE_WIDTH;

  logic [2:0][MainWidth-1:0] main_in;
  logic [2:0][GrpWidth-1:0]  data_in;
  logic [MainWidth-1:0]      main_out;
  logic [GrpWidth-1:0]       data_out;
  logic                      main_err;
  logic                      data_err;
  logic [2:0]                main_err_cba;
  logic [2:0]                data_err_cba;

  for (genvar i = 0; i < 3; i++) begin : gen_split
    assign main_in[i] = {core_req_i[i].irq_ack, core_req_i[i].irq_ack_id,
                         core_req_i[i].instr_req, core_req_i[i].instr_addr,
                         core_req_i[i].data_req};
    assign data_in[i] = {core_req_i[i].data_addr, core_req_i[i].data_we,
                         core_req_i[i].data_wdata, core_req_i[i].data_be};
  end

  bitwise_tmr_voter #(
    .DataWidth   ( MainWidth    )
  ) i_main_voter (
    .a_i         ( main_in[0]   ),
    .b_i         ( main_in[1]   ),
    .c_i         ( main_in[2]   ),
    .majority_o  ( main_out     ),
    .error_o     ( main_err     ),
    .error_cba_o ( main_err_cba )
  );

  bitwise_tmr_voter #(
    .DataWidth   ( GrpWidth     )
  ) i_data_voter (
    .a_i         ( data_in[0]   ),
    .b_i         ( data_in[1]   ),
    .c_i         ( data_in[2]   ),
    .majority_o  ( data_out     ),
    .error_o     ( data_err     ),
    .error_cba_o ( data_err_cba )
  );

  // Rebuild the request from the two voted groups
  always_comb begin
    {voted_req_o.irq_ack, voted_req_o.irq_ack_id, voted_req_o.instr_req,
     voted_req_o.instr_addr, voted_req_o.data_req} = main_out;
    {voted_req_o.data_addr, voted_req_o.data_we,
     voted_req_o.data_wdata, voted_req_o.data_be} = data_out;
  end

  // Idle data lines may differ freely between cores
  assign mismatch_core_o = main_err_cba | (data_err_cba & {3{voted_req_o.data_req}});
  assign mismatch_o      = main_err | (data_err & voted_req_o.data_req);

endmodule

`default_nettype wire

// File: design/tcls_unit.sv
// Triple-core lockstep unit between three cores and one interconnect port
// Requests are voted, responses and control fan out unchanged, no added latency
// Bus strobes pass through, the cores hold their requests until granted

`timescale 1ns/10ps
`default_nettype none

module tcls_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Core side
  input  tcls_bus_pkg::core_req_t  [2:0]  core_req_i,
  output tcls_bus_pkg::intc_rsp_t  [2:0]  core_rsp_o,
  output tcls_bus_pkg::core_ctrl_t [2:0]  core_ctrl_o,
  output logic                     [2:0]  core_setback_o,

  // Interconnect side
  output tcls_bus_pkg::core_req_t         intc_req_o,
  input  tcls_bus_pkg::intc_rsp_t         intc_rsp_i,
  input  tcls_bus_pkg::core_ctrl_t        ctrl_i,

  // Register bus
  input  tcls_reg_pkg::reg_req_t          reg_req_i,
  output tcls_reg_pkg::reg_rsp_t          reg_rsp_o,

  // Status
  output logic                            mismatch_o,
  output logic                     [2:0]  mismatch_core_o
);

  logic                    setback;
  logic [2:0]              count_inc;
  logic                    restore_mode;
  logic                    sp_store_zero;
  tcls_reg_pkg::red_mode_e red_mode;

  tcls_request_voter i_voter (
    .core_req_i      ( core_req_i      ),
    .voted_req_o     ( intc_req_o      ),
    .mismatch_o      ( mismatch_o      ),
    .mismatch_core_o ( mismatch_core_o )
  );

  tcls_recovery_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .fetch_en_i      ( ctrl_i.fetch_en ),
    .mismatch_core_i ( mismatch_core_o ),
    .restore_mode_i  ( restore_mode    ),
    .sp_store_zero_i ( sp_store_zero   ),
    .red_mode_o      ( red_mode        ),
    .count_inc_o     ( count_inc       ),
    .setback_o       ( setback         )
  );

  tcls_manager_regs i_regs (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .reg_req_i       ( reg_req_i       ),
    .count_inc_i     ( count_inc       ),
    .red_mode_i      ( red_mode        ),
    .reg_rsp_o       ( reg_rsp_o       ),
    .restore_mode_o  ( restore_mode    ),
    .sp_store_zero_o ( sp_store_zero   )
  );

  // Same response, control and setback to every core
  for (genvar i = 0; i < 3; i++) begin : gen_fanout
    assign core_rsp_o[i]     = intc_rsp_i;
    assign core_ctrl_o[i]    = ctrl_i;
    assign core_setback_o[i] = setback;
  end

endmodule

`default_nettype wire

// File: tcls.f
+incdir+common
common/tcls_bus_pkg.sv
common/tcls_reg_pkg.sv
design/bitwise_tmr_voter.sv
design/tcls_request_voter.sv
design/tcls_recovery_ctrl.sv
design/tcls_manager_regs.sv
design/tcls_unit.sv
testbench/tcls_tb.sv

// File: testbench/tcls_tb.sv
// Random self-checking testbench for the lockstep unit
// Inputs change on the rising edge, outputs are checked at the falling edge
// The reference model tracks voting, counters, redundancy state and setback

`timescale 1ns/10ps
`default_nettype none

`include "tcls_defines.svh"

module tcls_tb;

  typedef tcls_bus_pkg::core_req_t [2:0] req3_t;

  localparam int unsigned ReqBits   = $bits(tcls_bus_pkg::core_req_t);
  localparam int unsigned RspBits   = $bits(tcls_bus_pkg::intc_rsp_t);
  localparam int unsigned CtrlBits  = $bits(tcls_bus_pkg::core_ctrl_t);
  localparam int unsigned NumRandom = 2000;
  // Random vectors plus directed sequences plus reset, with margin
  localparam int unsigned MaxCycles = 4000;
  localparam tcls_reg_pkg::reg_req_t NoReg = '0;

  logic                            clk_i;
  logic                            rst_ni;
  req3_t                           core_req;
  tcls_bus_pkg::intc_rsp_t  [2:0]  core_rsp;
  tcls_bus_pkg::core_ctrl_t [2:0]  core_ctrl;
  logic                     [2:0]  core_setback;
  tcls_bus_pkg::core_req_t         intc_req;
  tcls_bus_pkg::intc_rsp_t         intc_rsp;
  tcls_bus_pkg::core_ctrl_t        ctrl;
  tcls_reg_pkg::reg_req_t          reg_req;
  tcls_reg_pkg::reg_rsp_t          reg_rsp;
  logic                            mismatch;
  logic                     [2:0]  mismatch_core;

  integer      seed;
  int unsigned cycle_cnt = 0;

  // Reference model state
  tcls_reg_pkg::red_mode_e          m_state;
  logic                             m_setback;
  logic                             m_restore;
  logic [`TCLS_DATA_WIDTH-1:0]      m_sp;
  logic [2:0][`TCLS_CNT_WIDTH-1:0]  m_cnt;

  tcls_unit uut (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .core_req_i      ( core_req      ),
    .core_rsp_o      ( core_rsp      ),
    .core_ctrl_o     ( core_ctrl     ),
    .core_setback_o  ( core_setback  ),
    .intc_req_o      ( intc_req      ),
    .intc_rsp_i      ( intc_rsp      ),
    .ctrl_i          ( ctrl          ),
    .reg_req_i       ( reg_req       ),
    .reg_rsp_o       ( reg_rsp       ),
    .mismatch_o      ( mismatch      ),
    .mismatch_core_o ( mismatch_core )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped after the first failure");
  endtask

  task automatic check_req(input tcls_bus_pkg::core_req_t got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_rsp(input tcls_bus_pkg::intc_rsp_t got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input tcls_bus_pkg::core_ctrl_t got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_reg(input tcls_reg_pkg::reg_rsp_t got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      abort_run();
    end
  endtask

  task automatic check_bits(input logic [2:0] got, exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, expected %b, got %b", $time, what, exp, got);
      abort_run();
    end
  endtask

  function automatic logic [127:0] rand_bits();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic tcls_bus_pkg::core_req_t rand_req();
    logic [127:0] b;
    b = rand_bits();
    return b[ReqBits-1:0];
  endfunction

  // Majority per bit, a tie between a and b is broken by c
  function automatic tcls_bus_pkg::core_req_t vote(input req3_t r);
    logic [ReqBits-1:0] a;
    logic [ReqBits-1:0] b;
    logic [ReqBits-1:0] c;
    logic [ReqBits-1:0] v;
    a = r[0];
    b = r[1];
    c = r[2];
    for (int i = 0; i < ReqBits; i++) begin
      v[i] = (a[i] == b[i]) ? a[i] : c[i];
    end
    return v;
  endfunction

  function automatic logic [2:0] expect_flags(input req3_t r, input tcls_bus_pkg::core_req_t v);
    tcls_bus_pkg::core_req_t dgrp;
    logic [ReqBits-1:0]      diff;
    logic [2:0]              f;
    dgrp            = '0;
    dgrp.data_addr  = '1;
    dgrp.data_we    = 1'b1;
    dgrp.data_wdata = '1;
    dgrp.data_be    = '1;
    for (int i = 0; i < 3; i++) begin
      diff = r[i] ^ v;
      f[i] = (|(diff & ~dgrp)) || (v.data_req && |(diff & dgrp));
    end
    return f;
  endfunction

  function automatic tcls_reg_pkg::reg_rsp_t expect_reg(input tcls_reg_pkg::reg_req_t q);
    tcls_reg_pkg::reg_rsp_t  e;
    tcls_reg_pkg::mode_reg_u mode;
    mode.raw                 = '0;
    mode.fields.state        = m_state;
    mode.fields.restore_mode = m_restore;
    e.rdata = '0;
    e.error = 1'b0;
    case (q.addr)
      `TCLS_REG_MODE:     e.rdata = mode.raw;
      `TCLS_REG_SP_STORE: e.rdata = m_sp;
      `TCLS_REG_MISMATCH_0,
      `TCLS_REG_MISMATCH_1,
      `TCLS_REG_MISMATCH_2: begin
        e.rdata = m_cnt[(q.addr - 5'h08) >> 2];
        e.error = q.write;
      end
      default: e.error = 1'b1;
    endcase
    return e;
  endfunction

  // Model update for the coming clock edge
  task automatic advance_model(input logic [2:0] f);
    tcls_reg_pkg::red_mode_e nstate;
    logic                    nsetback;
    nstate   = m_state;
    nsetback = 1'b0;
    case (m_state)
      tcls_reg_pkg::TMR_RUN: begin
        if (f != 3'b000 && !m_restore) nstate = tcls_reg_pkg::TMR_UNLOAD;
      end
      tcls_reg_pkg::TMR_UNLOAD: begin
        if (m_sp != '0) begin
          nstate   = tcls_reg_pkg::TMR_RELOAD;
          nsetback = 1'b1;
        end
      end
      default: begin
        if (m_sp == '0) nstate = tcls_reg_pkg::TMR_RUN;
      end
    endcase
    if (!ctrl.fetch_en) begin
      nstate   = tcls_reg_pkg::TMR_RUN;
      nsetback = 1'b0;
    end
    if (m_state == tcls_reg_pkg::TMR_RUN && (f == 3'b001 || f == 3'b010 || f == 3'b100)) begin
      for (int i = 0; i < 3; i++) begin
        if (f[i]) m_cnt[i] = m_cnt[i] + 1'b1;
      end
    end
    if (reg_req.valid && reg_req.write) begin
      if (reg_req.addr == `TCLS_REG_MODE) m_restore = reg_req.wdata[0];
      if (reg_req.addr == `TCLS_REG_SP_STORE) m_sp = reg_req.wdata;
    end
    m_state   = nstate;
    m_setback = nsetback;
  endtask

  task automatic check_cycle();
    tcls_bus_pkg::core_req_t v;
    logic [2:0]              f;
    v = vote(core_req);
    f = expect_flags(core_req, v);
    check_req(intc_req, v, "voted request");
    check_bits(mismatch_core, f, "per-core mismatch flags");
    check_bits({2'b00, mismatch}, {2'b00, |f}, "mismatch flag");
    check_bits(core_setback, {3{m_setback}}, "setback");
    for (int i = 0; i < 3; i++) begin
      check_rsp(core_rsp[i], intc_rsp, "response fanout");
      check_ctrl(core_ctrl[i], ctrl, "control fanout");
    end
    if (reg_req.valid) check_reg(reg_rsp, expect_reg(reg_req), "register response");
    advance_model(f);
  endtask

  task automatic bus_cycle(input req3_t req, input logic fetch_en,
                           input tcls_reg_pkg::reg_req_t rq);
    logic [127:0]             r1;
    logic [127:0]             r2;
    tcls_bus_pkg::core_ctrl_t c;
    r1         = rand_bits();
    r2         = rand_bits();
    c          = r2[CtrlBits-1:0];
    c.fetch_en = fetch_en;
    @(posedge clk_i);
    core_req <= req;
    intc_rsp <= r1[RspBits-1:0];
    ctrl     <= c;
    reg_req  <= rq;
    @(negedge clk_i);
    check_cycle();
  endtask

  task automatic reg_access(input logic write, input logic [4:0] addr, input logic [31:0] wdata);
    tcls_reg_pkg::reg_req_t  rq;
    tcls_bus_pkg::core_req_t base;
    rq.valid = 1'b1;
    rq.write = write;
    rq.addr  = addr;
    rq.wdata = wdata;
    base     = rand_req();
    bus_cycle({3{base}}, 1'b1, rq);
  endtask

  // One core drives a wrong instruction address
  task automatic inject_fault(input int unsigned core);
    tcls_bus_pkg::core_req_t base;
    req3_t                   req;
    base = rand_req();
    req  = {3{base}};
    req[core].instr_addr[3] = ~base.instr_addr[3];
    bus_cycle(req, 1'b1, NoReg);
  endtask

  task automatic require_state(input tcls_reg_pkg::red_mode_e s, input string what);
    if (m_state != s) begin
      $display("The test sequence did not reach the %s state", what);
      abort_run();
    end
  endtask

  initial begin : stimulus
    tcls_bus_pkg::core_req_t base;
    req3_t                   req;
    logic [ReqBits-1:0]      tmp;
    int unsigned             k;
    int unsigned             nflip;
    int unsigned             pos;
    seed      = 32'he927_d3cb;
    rst_ni    = 1'b0;
    core_req  = '0;
    intc_rsp  = '0;
    ctrl      = '0;
    reg_req   = '0;
    m_state   = tcls_reg_pkg::TMR_RUN;
    m_setback = 1'b0;
    m_restore = 1'b0;
    m_sp      = '0;
    m_cnt     = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Count only, so random faults never leave RUN
    reg_access(1'b1, `TCLS_REG_MODE, 32'h1);
    for (int n = 0; n < NumRandom; n++) begin
      base = rand_req();
      req  = {3{base}};
      k    = $unsigned($random(seed)) % 4;
      if (k < 3) begin
        tmp   = req[k];
        nflip = 1 + $unsigned($random(seed)) % 3;
        for (int j = 0; j < nflip; j++) begin
          pos      = $unsigned($random(seed)) % ReqBits;
          tmp[pos] = ~tmp[pos];
        end
        req[k] = tmp;
      end
      bus_cycle(req, 1'b1, NoReg);
    end
    reg_access(1'b0, `TCLS_REG_MISMATCH_0, '0);
    reg_access(1'b0, `TCLS_REG_MISMATCH_1, '0);
    reg_access(1'b0, `TCLS_REG_MISMATCH_2, '0);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_RUN, "run");

    // Bad accesses leave every register as it was
    reg_access(1'b1, `TCLS_REG_MISMATCH_1, 32'hdead_beef);
    reg_access(1'b0, `TCLS_REG_MISMATCH_1, '0);
    reg_access(1'b0, 5'h14, '0);
    reg_access(1'b1, 5'h18, 32'hffff_ffff);
    // Clears restore_mode if it ever reached MODE
    reg_access(1'b1, 5'h02, 32'hffff_fffe);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    reg_access(1'b0, `TCLS_REG_SP_STORE, '0);

    // Full recovery round trip
    reg_access(1'b1, `TCLS_REG_MODE, 32'h0000_0006);
    inject_fault(1);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_UNLOAD, "unload");
    reg_access(1'b1, `TCLS_REG_SP_STORE, 32'h0000_1234);
    reg_access(1'b0, `TCLS_REG_SP_STORE, '0);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_RELOAD, "reload");
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    reg_access(1'b1, `TCLS_REG_SP_STORE, '0);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_RUN, "run");

    // fetch_en low aborts the unload
    inject_fault(2);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_UNLOAD, "unload");
    base = rand_req();
    bus_cycle({3{base}}, 1'b0, NoReg);
    reg_access(1'b0, `TCLS_REG_MODE, '0);
    require_state(tcls_reg_pkg::TMR_RUN, "run");
    reg_access(1'b0, `TCLS_REG_MISMATCH_2, '0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
